// ==== rtl/graph_pkg.sv ====
package graph_pkg;

	// Every record field is one 16-bit word.
	localparam int FIELD_W     = 16;
	localparam int FIELD_COUNT = 17;                   // x, y, id, parent, cost, six id/dist pairs.
	localparam int REC_W       = FIELD_W * FIELD_COUNT; // 272 bits per record.
	localparam int ADDR_W      = 7;
	localparam int NODE_COUNT  = 128;                  // One record per address.
	localparam int CHILD_SLOTS = 6;

	// Id that marks an empty slot in the child results.
	localparam int NO_NODE_ID = 800;

	// Field positions inside a record, most significant field first.
	localparam int X_LSB      = 256;
	localparam int Y_LSB      = 240;
	localparam int ID_LSB     = 224;
	localparam int PARENT_LSB = 208;
	localparam int COST_LSB   = 192;

	// Child pairs follow the cost field, each id directly above its distance.
	localparam int CHILD_ID_LSB [CHILD_SLOTS]   = '{176, 144, 112, 80, 48, 16};
	localparam int CHILD_DIST_LSB [CHILD_SLOTS] = '{160, 128, 96, 64, 32, 0};

	typedef logic [FIELD_W-1:0] node_id_t;
	typedef logic [ADDR_W-1:0]  node_addr_t;
	typedef logic [REC_W-1:0]   node_rec_t;
	typedef logic [2:0]         child_cnt_t; // Counts up to CHILD_SLOTS.

	// An empty record has only its id field set.
	localparam node_rec_t EMPTY_REC = node_rec_t'(NO_NODE_ID) << ID_LSB;

	// Each scanned address walks through ADDR, WAIT and CHECK.
	typedef enum logic [3:0] {
		ST_IDLE,
		ST_NODE_ADDR,   // Address of the record under test is on the RAM.
		ST_NODE_WAIT,   // Registered read is in flight.
		ST_NODE_CHECK,  // Compare the record id with the requested id.
		ST_CHILD_START, // Rewind to address 0 for the child scan.
		ST_CHILD_ADDR,
		ST_CHILD_WAIT,
		ST_CHILD_CHECK, // Collector compares against the six child ids.
		ST_DONE
	} reader_state_t;

endpackage

// ==== rtl/node_mem.sv ====
module node_mem (
	input  logic                 clk,
	input  logic                 reset,
	input  logic                 wb_cyc,
	input  logic                 wb_stb,
	input  logic                 wb_we,
	input  graph_pkg::node_addr_t wb_adr,
	input  graph_pkg::node_rec_t  wb_dat_w,
	output logic                 wb_ack,
	input  graph_pkg::node_addr_t read_addr,
	output graph_pkg::node_rec_t  read_rec
);
	import graph_pkg::*;

	node_rec_t mem [NODE_COUNT]; // One whole record per word.
	logic      wb_req;           // Valid Wishbone cycle this clock.
	logic      wb_write;

	assign wb_req = wb_cyc && wb_stb;

	// A request held through its ack cycle must not be taken twice.
	assign wb_write = wb_req && wb_we && !wb_ack;

	// Single-cycle acknowledge, one clock after the request shows up.
	always_ff @(posedge clk) begin
		if (reset) begin
			wb_ack <= 1'b0;
		end else begin
			wb_ack <= wb_req && !wb_ack; // Reads are acked too, they just return nothing.
		end
	end

	// The write lands on the same edge that raises wb_ack.
	always_ff @(posedge clk) begin
		if (wb_write) begin
			mem[wb_adr] <= wb_dat_w;
		end
	end

	// Registered read port for the lookup FSM.
	always_ff @(posedge clk) begin
		read_rec <= mem[read_addr]; // Data is valid one cycle after the address.
	end

	// The host drops its strobe after the ack, so acks never come back to back.
	a_ack_single : assert property (
		@(posedge clk) disable iff (reset)
		wb_ack |=> !wb_ack
	);

endmodule

// ==== rtl/child_collector.sv ====
module child_collector (
	input  logic                clk,
	input  logic                reset,
	input  logic                clear_slots,
	input  logic                check_child,
	input  graph_pkg::node_rec_t node_rec,
	input  graph_pkg::node_rec_t read_rec,
	output graph_pkg::node_rec_t child_rec [graph_pkg::CHILD_SLOTS],
	output logic                all_found
);
	import graph_pkg::*;

	child_cnt_t             child_cnt; // Children stored so far.
	node_id_t               rec_id;    // Id of the record on the read port.
	logic [CHILD_SLOTS-1:0] id_hit;    // Record id equals child id i.
	logic [CHILD_SLOTS-1:0] first_hit; // Lowest matching slot only.

	assign rec_id = read_rec[ID_LSB +: FIELD_W];

	// Compare against all six child ids of the captured node.
	// An id of zero marks an unused child field and never matches.
	always_comb begin
		for (int i = 0; i < CHILD_SLOTS; i++) begin
			id_hit[i] = (rec_id != '0) && (rec_id == node_rec[CHILD_ID_LSB[i] +: FIELD_W]);
		end
	end

	// Slot 0 has the highest priority, so the downward loop lets it win.
	always_comb begin
		first_hit = '0;
		for (int i = CHILD_SLOTS - 1; i >= 0; i--) begin
			if (id_hit[i]) begin
				first_hit    = '0;
				first_hit[i] = 1'b1;
			end
		end
	end

	always_ff @(posedge clk) begin
		if (reset || clear_slots) begin
			for (int i = 0; i < CHILD_SLOTS; i++) begin
				child_rec[i] <= EMPTY_REC; // Unmatched children read back as id 800.
			end
			child_cnt <= '0;
		end else if (check_child && (first_hit != '0)) begin
			for (int i = 0; i < CHILD_SLOTS; i++) begin
				if (first_hit[i]) begin
					child_rec[i] <= read_rec;
				end
			end
			child_cnt <= child_cnt + 1'b1;
		end
	end

	assign all_found = (child_cnt == child_cnt_t'(CHILD_SLOTS)); // Lets the scan stop early.

	// The reader stops checking once all_found is up, which bounds the count.
	a_cnt_bound : assert property (
		@(posedge clk) disable iff (reset)
		child_cnt <= child_cnt_t'(CHILD_SLOTS)
	);

endmodule

// ==== rtl/node_reader.sv ====
module node_reader (
	input  logic                 clk,
	input  logic                 reset,
	input  logic                 find_node,
	input  graph_pkg::node_id_t   node_id,
	input  graph_pkg::node_rec_t  read_rec,
	input  logic                 all_found,
	output graph_pkg::node_addr_t read_addr,
	output graph_pkg::node_rec_t  node_rec,
	output logic                 found,
	output logic                 clear_slots,
	output logic                 check_child,
	output logic                 done,
	output logic                 busy
);
	import graph_pkg::*;

	reader_state_t state;
	node_id_t      target_id; // Requested id held for the whole lookup.
	node_id_t      rec_id;
	logic          node_hit;
	logic          last_addr;
	logic          accept;

	assign rec_id    = read_rec[ID_LSB +: FIELD_W];
	assign node_hit  = (rec_id != '0) && (rec_id == target_id); // Id 0 is never a node.
	assign last_addr = (read_addr == node_addr_t'(NODE_COUNT - 1));
	assign accept    = (state == ST_IDLE) && find_node; // Pulses elsewhere are dropped.

	// Lookup FSM. Each address takes three cycles in either scan.
	always_ff @(posedge clk) begin
		if (reset) begin
			state     <= ST_IDLE;
			found     <= 1'b0;
			read_addr <= '0;
		end else begin
			case (state)
				ST_IDLE: begin
					if (accept) begin
						state     <= ST_NODE_ADDR;
						found     <= 1'b0; // Results of the previous lookup end here.
						read_addr <= '0;
					end
				end
				ST_NODE_ADDR: state <= ST_NODE_WAIT;
				ST_NODE_WAIT: state <= ST_NODE_CHECK;
				ST_NODE_CHECK: begin
					if (node_hit) begin
						found <= 1'b1;
						state <= ST_CHILD_START;
					end else if (last_addr) begin
						state <= ST_DONE; // An absent id skips the child scan.
					end else begin
						read_addr <= read_addr + 1'b1;
						state     <= ST_NODE_ADDR;
					end
				end
				ST_CHILD_START: begin
					read_addr <= '0; // Children may sit anywhere in memory.
					state     <= ST_CHILD_ADDR;
				end
				ST_CHILD_ADDR: state <= ST_CHILD_WAIT;
				ST_CHILD_WAIT: state <= ST_CHILD_CHECK;
				ST_CHILD_CHECK: begin
					// all_found lags the collector by one check.
					if (all_found || last_addr) begin
						state <= ST_DONE;
					end else begin
						read_addr <= read_addr + 1'b1;
						state     <= ST_CHILD_ADDR;
					end
				end
				ST_DONE: state <= ST_IDLE;
				default: state <= ST_IDLE;
			endcase
		end
	end

	// Request id and node record load only at accept and on the match.
	always_ff @(posedge clk) begin
		if (accept) begin
			target_id <= node_id;
			node_rec  <= EMPTY_REC;
		end else if ((state == ST_NODE_CHECK) && node_hit) begin
			node_rec <= read_rec; // This is what the collector matches children against.
		end
	end

	assign clear_slots = accept;
	assign check_child = (state == ST_CHILD_CHECK) && !all_found;
	assign done        = (state == ST_DONE);
	assign busy        = (state != ST_IDLE);

	a_done_pulse : assert property (
		@(posedge clk) disable iff (reset)
		done |=> !done
	);

endmodule

// ==== rtl/graph_lookup_top.sv ====
module graph_lookup_top (
	input  logic                 clk,
	input  logic                 reset,
	input  logic                 wb_cyc,
	input  logic                 wb_stb,
	input  logic                 wb_we,
	input  graph_pkg::node_addr_t wb_adr,
	input  graph_pkg::node_rec_t  wb_dat_w,
	output logic                 wb_ack,
	input  logic                 find_node,
	input  graph_pkg::node_id_t   node_id,
	output logic                 done,
	output logic                 found,
	output graph_pkg::node_rec_t  node_rec,
	output graph_pkg::node_rec_t  child_rec [graph_pkg::CHILD_SLOTS]
);
	import graph_pkg::*;

	node_addr_t read_addr;  // Reader to RAM.
	node_rec_t  read_rec;   // RAM to reader and collector.
	logic       clear_slots;
	logic       check_child;
	logic       all_found;
	logic       busy;

	node_mem node_mem_i (
		.clk       (clk),
		.reset     (reset),
		.wb_cyc    (wb_cyc),
		.wb_stb    (wb_stb),
		.wb_we     (wb_we),
		.wb_adr    (wb_adr),
		.wb_dat_w  (wb_dat_w),
		.wb_ack    (wb_ack),
		.read_addr (read_addr),
		.read_rec  (read_rec)
	);

	node_reader node_reader_i (
		.clk         (clk),
		.reset       (reset),
		.find_node   (find_node),
		.node_id     (node_id),
		.read_rec    (read_rec),
		.all_found   (all_found),
		.read_addr   (read_addr),
		.node_rec    (node_rec),
		.found       (found),
		.clear_slots (clear_slots),
		.check_child (check_child),
		.done        (done),
		.busy        (busy)
	);

	child_collector child_collector_i (
		.clk         (clk),
		.reset       (reset),
		.clear_slots (clear_slots),
		.check_child (check_child),
		.node_rec    (node_rec),
		.read_rec    (read_rec),
		.child_rec   (child_rec),
		.all_found   (all_found)
	);

	// Memory contents must stay put while a scan walks through them.
	a_no_wb_busy : assert property (
		@(posedge clk) disable iff (reset)
		(wb_cyc && wb_stb) |-> !busy
	);

endmodule

// ==== test/tb_graph_lookup.sv ====
module tb_graph_lookup;
	import graph_pkg::*;

	localparam int CYCLE_LIMIT = 10000; // Memory fill plus five full-length lookups stay far below.
	localparam int REC_COUNT   = 20;    // Records placed at random addresses.

	logic       clk;
	logic       reset;
	logic       wb_cyc;
	logic       wb_stb;
	logic       wb_we;
	node_addr_t wb_adr;
	node_rec_t  wb_dat_w;
	logic       wb_ack;
	logic       find_node;
	node_id_t   node_id;
	logic       done;
	logic       found;
	node_rec_t  node_rec;
	node_rec_t  child_rec [CHILD_SLOTS];

	node_rec_t   model_mem [NODE_COUNT]; // Mirror of every record written to the DUT.
	node_id_t    rec_ids [REC_COUNT];
	logic        exp_found;
	node_rec_t   exp_node;
	node_rec_t   exp_child [CHILD_SLOTS];
	logic [31:0] lcg_state;
	int          errors = 0;
	int          tests_run = 0;
	int          tests_failed = 0;
	int          err_mark = 0;
	int          cycle_cnt = 0;

	graph_lookup_top graph_lookup_top_i (
		.clk       (clk),
		.reset     (reset),
		.wb_cyc    (wb_cyc),
		.wb_stb    (wb_stb),
		.wb_we     (wb_we),
		.wb_adr    (wb_adr),
		.wb_dat_w  (wb_dat_w),
		.wb_ack    (wb_ack),
		.find_node (find_node),
		.node_id   (node_id),
		.done      (done),
		.found     (found),
		.node_rec  (node_rec),
		.child_rec (child_rec)
	);

	initial begin
		clk = 1'b0;
		forever #50 clk = ~clk; // Period of 100.
	end

	// Hard stop in case a handshake never completes.
	always @(posedge clk) begin
		cycle_cnt <= cycle_cnt + 1;
		if (cycle_cnt >= CYCLE_LIMIT) begin
			$display("Run stopped after %0d cycles before all tests finished.", cycle_cnt);
			$display("TESTBENCH FAILED");
			$finish;
		end
	end

	// Outputs settle low one edge into reset.
	a_reset_quiet : assert property (@(posedge clk) reset |=> (!done && !found && !wb_ack))
		else begin
			$display("FAILED %0t done/found/wb_ack: got %b%b%b expected 000",
				$time, done, found, wb_ack);
			errors = errors + 1;
		end

	// A fresh request is acknowledged on the next edge.
	a_write_acked : assert property (@(posedge clk) disable iff (reset)
		(wb_cyc && wb_stb && !wb_ack) |=> wb_ack)
		else begin
			$display("FAILED %0t wb_ack: got %b expected 1", $time, wb_ack);
			errors = errors + 1;
		end

	a_found_at_done : assert property (@(posedge clk) disable iff (reset)
		done |-> (found == exp_found))
		else begin
			$display("FAILED %0t found: got %b expected %b", $time, found, exp_found);
			errors = errors + 1;
		end

	a_node_at_done : assert property (@(posedge clk) disable iff (reset)
		(done && exp_found) |-> (node_rec == exp_node))
		else begin
			$display("FAILED %0t node_rec: got %h expected %h", $time, node_rec, exp_node);
			errors = errors + 1;
		end

	// Plain LCG that returns the upper half of its state.
	function automatic logic [15:0] next_random();
		lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
		return lcg_state[31:16]; // Low bits of an LCG repeat too soon.
	endfunction

	function automatic node_id_t rec_id_of(input node_rec_t rec);
		return rec[ID_LSB +: FIELD_W];
	endfunction

	// Random payload around a given id with all child ids zero.
	function automatic node_rec_t make_record(input node_id_t id);
		node_rec_t rec;
		rec = '0;
		rec[X_LSB +: FIELD_W]      = next_random();
		rec[Y_LSB +: FIELD_W]      = next_random();
		rec[ID_LSB +: FIELD_W]     = id;
		rec[PARENT_LSB +: FIELD_W] = next_random(); // The lookup never follows the parent.
		rec[COST_LSB +: FIELD_W]   = next_random();
		for (int i = 0; i < CHILD_SLOTS; i++) begin
			rec[CHILD_DIST_LSB[i] +: FIELD_W] = next_random();
		end
		return rec;
	endfunction

	// One Wishbone write whose single ack is checked.
	task automatic write_record(input node_addr_t addr, input node_rec_t rec);
		wb_cyc   = 1'b1;
		wb_stb   = 1'b1;
		wb_we    = 1'b1;
		wb_adr   = addr;
		wb_dat_w = rec;
		do @(negedge clk); while (!wb_ack); // Hold the request until it is taken.
		wb_cyc = 1'b0;
		wb_stb = 1'b0;
		@(negedge clk);
		assert (!wb_ack) else begin
			$display("FAILED %0t wb_ack: got %b expected 0", $time, wb_ack);
			errors = errors + 1;
		end
		model_mem[addr] = rec;
	endtask

	// Expected results from the model memory.
	task automatic predict_results(input node_id_t id);
		node_id_t cid;
		logic     dup;
		exp_found = 1'b0;
		exp_node  = EMPTY_REC;
		for (int i = 0; i < CHILD_SLOTS; i++) begin
			exp_child[i] = EMPTY_REC;
		end
		for (int a = 0; a < NODE_COUNT; a++) begin
			if (!exp_found && (id != '0) && (rec_id_of(model_mem[a]) == id)) begin
				exp_found = 1'b1; // First address wins.
				exp_node  = model_mem[a];
			end
		end
		if (exp_found) begin
			for (int i = 0; i < CHILD_SLOTS; i++) begin
				cid = exp_node[CHILD_ID_LSB[i] +: FIELD_W];
				dup = 1'b0;
				for (int j = 0; j < i; j++) begin
					if (exp_node[CHILD_ID_LSB[j] +: FIELD_W] == cid) dup = 1'b1; // Lower slot takes it.
				end
				for (int a = NODE_COUNT - 1; a >= 0; a--) begin
					if ((cid != '0) && !dup && (rec_id_of(model_mem[a]) == cid)) begin
						exp_child[i] = model_mem[a];
					end
				end
			end
		end
	endtask

	task automatic check_children();
		for (int i = 0; i < CHILD_SLOTS; i++) begin
			assert (child_rec[i] == exp_child[i]) else begin
				$display("FAILED %0t child_rec[%0d]: got %h expected %h",
					$time, i, child_rec[i], exp_child[i]);
				errors = errors + 1;
			end
		end
	endtask

	// A stray_delay above zero sends a second pulse while the first lookup runs.
	task automatic run_lookup(input node_id_t id, input int stray_delay, input node_id_t stray_id);
		predict_results(id);
		node_id   = id;
		find_node = 1'b1;
		@(negedge clk);
		find_node = 1'b0;
		if (stray_delay > 0) begin
			repeat (stray_delay) @(negedge clk); // The node scan alone takes three cycles.
			node_id   = stray_id;
			find_node = 1'b1;
			@(negedge clk);
			find_node = 1'b0;
		end
		while (!done) @(negedge clk);
		check_children();
		@(negedge clk);
	endtask

	task automatic end_test(input string name);
		tests_run = tests_run + 1;
		if (errors > err_mark) begin
			tests_failed = tests_failed + 1;
			$display("Test %0s: failed with %0d errors", name, errors - err_mark);
		end else begin
			$display("Test %0s: ok", name);
		end
		err_mark = errors;
	endtask

	initial begin
		node_rec_t   rec;
		logic [15:0] r;
		node_addr_t  addr;
		logic        used [NODE_COUNT];
		lcg_state = 32'h85eb_8cb6;
		reset     = 1'b1;
		wb_cyc    = 1'b0;
		wb_stb    = 1'b0;
		wb_we     = 1'b0;
		wb_adr    = '0;
		wb_dat_w  = '0;
		find_node = 1'b0;
		node_id   = '0;
		exp_found = 1'b0;
		exp_node  = EMPTY_REC;
		for (int i = 0; i < CHILD_SLOTS; i++) exp_child[i] = EMPTY_REC;
		repeat (5) @(posedge clk);
		@(negedge clk);
		reset = 1'b0;

		assert (!done && !found && !wb_ack) else begin
			$display("FAILED %0t done/found/wb_ack: got %b%b%b expected 000",
				$time, done, found, wb_ack);
			errors = errors + 1;
		end
		// Zero records everywhere first since id 0 never matches.
		for (int a = 0; a < NODE_COUNT; a++) begin
			write_record(node_addr_t'(a), '0);
			used[a] = 1'b0;
		end
		for (int k = 0; k < REC_COUNT; k++) begin
			rec_ids[k] = node_id_t'(21 + 13 * k); // Distinct, nonzero, never 800.
		end
		for (int k = 0; k < REC_COUNT; k++) begin
			rec = make_record(rec_ids[k]);
			for (int i = 0; i < CHILD_SLOTS; i++) begin
				r = next_random();
				if (k == 0) begin
					rec[CHILD_ID_LSB[i] +: FIELD_W] = rec_ids[i + 1]; // All six stored.
				end else if (r[2:0] >= 3'd3) begin
					rec[CHILD_ID_LSB[i] +: FIELD_W] = rec_ids[int'(r[15:8]) % REC_COUNT];
				end
			end
			if (k == 7) begin
				// Mix of stored, zero and absent children.
				rec[CHILD_ID_LSB[0] +: FIELD_W] = rec_ids[8];
				rec[CHILD_ID_LSB[1] +: FIELD_W] = '0;
				rec[CHILD_ID_LSB[2] +: FIELD_W] = rec_ids[9];
				rec[CHILD_ID_LSB[3] +: FIELD_W] = 16'd999;
				rec[CHILD_ID_LSB[4] +: FIELD_W] = '0;
				rec[CHILD_ID_LSB[5] +: FIELD_W] = rec_ids[10];
			end
			do begin
				r    = next_random();
				addr = r[6:0];
			end while (used[addr]);
			used[addr] = 1'b1;
			write_record(addr, rec);
		end
		end_test("reset and record load");

		run_lookup(rec_ids[12], 0, '0);
		end_test("stored node");
		run_lookup(rec_ids[0], 0, '0);
		end_test("six stored children");
		run_lookup(rec_ids[7], 0, '0);
		end_test("zero and absent children");
		run_lookup(16'd555, 0, '0);
		end_test("absent node");
		run_lookup(rec_ids[14], 2, rec_ids[0]);
		end_test("pulse during lookup");

		$display("%0d tests run, %0d failed, %0d errors", tests_run, tests_failed, errors);
		if (errors == 0) begin
			$display("TESTBENCH PASSED");
		end else begin
			$display("TESTBENCH FAILED");
		end
		$finish;
	end

endmodule

// ==== filelist.f ====
rtl/graph_pkg.sv
rtl/node_mem.sv
rtl/child_collector.sv
rtl/node_reader.sv
rtl/graph_lookup_top.sv
test/tb_graph_lookup.sv

// ==== run.sh ====
#!/bin/sh
# Build the testbench with Verilator, run it and scan the log.

cd "$(dirname "$0")" || exit 1

LOG=sim.log
BUILD_DIR=obj_dir

verilator --binary --timing --assert -f filelist.f --top-module tb_graph_lookup \
	--Mdir "$BUILD_DIR" -o sim_tb
if [ $? -ne 0 ]; then
	echo "Verilator build failed."
	exit 1
fi

"./$BUILD_DIR/sim_tb" > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
	echo "Simulation exited with status $status."
	exit 1
fi

if grep -q "TESTBENCH FAILED" "$LOG"; then
	exit 1
fi
exit 0
